//--- sim.f
+incdir+logic
logic/mem_op_pkg.sv
logic/axi_lite_pkg.sv
logic/lsu.sv
logic/axi_ram.sv
logic/lsu_mem_top.sv
testbench/tb_lsu_mem.sv

//--- Bender.yml
package:
  name: lsu_mem

sources:
  - include_dirs:
      - logic
    files:
      - logic/mem_op_pkg.sv
      - logic/axi_lite_pkg.sv
      - logic/lsu.sv
      - logic/axi_ram.sv
      - logic/lsu_mem_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/tb_lsu_mem.sv

//--- testbench/tb_lsu_mem.sv
`include "lsu_cfg.svh"

module tb_lsu_mem;
  import mem_op_pkg::*;

  localparam int N_ST        = 200;
  localparam int N_LD        = 200;
  localparam int N_WORDS     = 16;
  localparam int CYCLE_LIMIT = 20 * (N_ST + N_LD);

  logic                   clk = 1'b0;
  logic                   rstn;
  logic                   ld_valid, ld_ready, ld_res_valid, ld_res_ready;
  logic [`LSU_ADDR_W-1:0] ld_addr, st_addr;
  ld_func_e               ld_func;
  logic [31:0]            ld_data, st_data;
  logic                   st_valid, st_ready, st_done_valid, st_done_ready;
  st_func_e               st_func;

  // byte-lane copy of what the memory should hold
  logic [7:0]  shadow [`RAM_WORDS*4];
  logic [31:0] exp_q [$];
  logic [31:0] exp_head;
  int          exp_cnt, errors, cycles;
  int          st_acc, st_done, ld_acc, ld_done, n_st, n_ld;
  ld_func_e    ld_kinds [5] = '{LD_BS, LD_BU, LD_HS, LD_HU, LD_W};

  lsu_mem_top UUT (.*);

  always #4 clk = ~clk;

  // result and completion sinks stall about 30% of cycles
  always @(negedge clk) begin
    if (!rstn) begin
      ld_res_ready  <= ($urandom % 10) >= 3;
      st_done_ready <= ($urandom % 10) >= 3;
    end
  end

  task automatic update_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt > 0) ? exp_q[0] : '0;
  endtask

  function automatic logic [31:0] expect_load(input int a, input ld_func_e f);
    logic [7:0]  b;
    logic [15:0] h;
    b = shadow[a];
    h = {shadow[a+1], shadow[a]};
    case (f)
      LD_BS:   return {{24{b[7]}}, b};
      LD_BU:   return {24'h0, b};
      LD_HS:   return {{16{h[15]}}, h};
      LD_HU:   return {16'h0, h};
      default: return {shadow[a+3], shadow[a+2], h};
    endcase
  endfunction

  task automatic send_store();
    int sel, n, acc, i;
    sel      = $urandom % 3;
    n        = 1 << sel;
    st_func  = st_func_e'(sel);
    st_addr  = 4 * ($urandom % N_WORDS) + n * ($urandom % (4 / n));
    st_data  = $urandom;
    st_valid = 1'b1;
    acc      = 0;
    while (!acc) begin
      acc = st_ready;
      @(negedge clk);
    end
    st_valid = 1'b0;
    st_acc++;
    for (i = 0; i < n; i++) begin
      shadow[st_addr+i] = st_data[8*i +: 8];
    end
  endtask

  task automatic send_load();
    int n, acc;
    ld_func_e f;
    // loads wait until every store has completed
    while (st_acc != st_done) @(negedge clk);
    f        = ld_kinds[$urandom % 5];
    n        = 1 << f[1:0];
    ld_func  = f;
    ld_addr  = 4 * ($urandom % N_WORDS) + n * ($urandom % (4 / n));
    ld_valid = 1'b1;
    acc      = 0;
    while (!acc) begin
      acc = ld_ready;
      @(negedge clk);
    end
    ld_valid = 1'b0;
    ld_acc++;
    exp_q.push_back(expect_load(ld_addr, f));
    update_head();
  endtask

  always @(posedge clk) begin
    if (!rstn && ld_res_valid && ld_res_ready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      ld_done++;
      update_head();
    end
    if (!rstn && st_done_valid && st_done_ready) st_done++;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with requests still open", CYCLE_LIMIT);
      $display("errors %0d, stores %0d/%0d done, loads %0d/%0d done",
               errors, st_done, st_acc, ld_done, ld_acc);
      $display("Something failed");
      $finish;
    end
  end

  a_reset_idle: assert property (@(posedge clk)
    rstn |=> !ld_res_valid && !st_done_valid && st_ready && ld_ready)
    else begin
      errors++;
      $display("[ERROR] %0t: outputs not idle around reset", $time);
    end

  a_ld_value: assert property (@(posedge clk) disable iff (rstn)
    ld_res_valid && ld_res_ready |-> exp_cnt > 0 && ld_data == exp_head)
    else begin
      errors++;
      $display("[ERROR] %0t: load data %08h, expected %08h", $time,
               $sampled(ld_data), $sampled(exp_head));
    end

  a_ld_hold: assert property (@(posedge clk) disable iff (rstn)
    ld_res_valid && !ld_res_ready |=> ld_res_valid && $stable(ld_data))
    else begin
      errors++;
      $display("[ERROR] %0t: load result changed while stalled", $time);
    end

  a_st_hold: assert property (@(posedge clk) disable iff (rstn)
    st_done_valid && !st_done_ready |=> st_done_valid)
    else begin
      errors++;
      $display("[ERROR] %0t: store completion dropped while stalled", $time);
    end

  a_done_count: assert property (@(posedge clk) disable iff (rstn) st_done <= st_acc)
    else begin
      errors++;
      $display("[ERROR] %0t: %0d completions for %0d stores", $time, st_done, st_acc);
    end

  initial begin
    void'($urandom(70));
    rstn          = 1'b1;
    ld_valid      = 1'b0;
    ld_addr       = '0;
    ld_func       = LD_W;
    ld_res_ready  = 1'b1;
    st_valid      = 1'b0;
    st_addr       = '0;
    st_data       = '0;
    st_func       = ST_W;
    st_done_ready = 1'b1;
    for (int i = 0; i < `RAM_WORDS * 4; i++) begin
      shadow[i] = 8'h00;
    end
    update_head();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rstn <= 1'b0;

    while (n_st < N_ST || n_ld < N_LD) begin
      if (n_ld == N_LD || (n_st < N_ST && ($urandom % 2) == 1)) begin
        send_store();
        n_st++;
      end else begin
        send_load();
        n_ld++;
      end
    end
    while (st_done != st_acc || ld_done != ld_acc) @(negedge clk);
    repeat (4) @(negedge clk);

    $display("errors %0d, stores %0d/%0d done, loads %0d/%0d done",
             errors, st_done, st_acc, ld_done, ld_acc);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- logic/lsu_mem_top.sv
`include "lsu_cfg.svh"

module lsu_mem_top (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    ld_valid,
  output logic                    ld_ready,
  input  logic [`LSU_ADDR_W-1:0]  ld_addr,
  input  mem_op_pkg::ld_func_e    ld_func,
  output logic                    ld_res_valid,
  input  logic                    ld_res_ready,
  output logic [31:0]             ld_data,
  input  logic                    st_valid,
  output logic                    st_ready,
  input  logic [`LSU_ADDR_W-1:0]  st_addr,
  input  logic [31:0]             st_data,
  input  mem_op_pkg::st_func_e    st_func,
  output logic                    st_done_valid,
  input  logic                    st_done_ready
);
  import axi_lite_pkg::*;

  // bus between lsu and memory
  logic                   ar_valid, ar_ready;
  logic [`LSU_ADDR_W-1:0] ar_addr;
  logic                   r_valid, r_ready;
  logic [31:0]            r_data;
  axi_resp_e              r_resp;
  logic                   aw_valid, aw_ready;
  logic [`LSU_ADDR_W-1:0] aw_addr;
  logic                   w_valid, w_ready;
  logic [31:0]            w_data;
  logic [3:0]             w_strb;
  logic                   b_valid, b_ready;
  axi_resp_e              b_resp;

  lsu u_lsu (.*);

  axi_ram u_ram (.*);

endmodule

//--- logic/axi_ram.sv
`include "lsu_cfg.svh"

module axi_ram (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ar_valid,
  output logic                      ar_ready,
  input  logic [`LSU_ADDR_W-1:0]    ar_addr,
  output logic                      r_valid,
  input  logic                      r_ready,
  output logic [31:0]               r_data,
  output axi_lite_pkg::axi_resp_e   r_resp,
  input  logic                      aw_valid,
  output logic                      aw_ready,
  input  logic [`LSU_ADDR_W-1:0]    aw_addr,
  input  logic                      w_valid,
  output logic                      w_ready,
  input  logic [31:0]               w_data,
  input  logic [3:0]                w_strb,
  output logic                      b_valid,
  input  logic                      b_ready,
  output axi_lite_pkg::axi_resp_e   b_resp
);
  import axi_lite_pkg::*;

  localparam int IDX_W = $clog2(`RAM_WORDS);

  logic [31:0]      mem [`RAM_WORDS];
  logic             aw_full, w_full, do_write;
  logic [IDX_W-1:0] aw_idx;
  bus_word_u        w_word, old_word, new_word;
  logic [3:0]       w_strb_q;
  logic [31:0]      rq_data [2];
  logic             rq_wr, rq_rd;
  logic [1:0]       rq_count;
  logic             ar_fire, r_fire;

  // write slots, filled in any order
  assign aw_ready = !aw_full;
  assign w_ready  = !w_full;
  assign do_write = aw_full && w_full && !b_valid;
  assign b_resp   = OKAY;

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) aw_full <= 1'b1;
      if (w_valid && w_ready) w_full <= 1'b1;
      if (do_write) b_valid <= 1'b1;
      if (b_valid && b_ready) begin
        b_valid <= 1'b0;
        aw_full <= 1'b0;
        w_full  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) aw_idx <= aw_addr[IDX_W+1:2];
    if (w_valid && w_ready) begin
      w_word.word <= w_data;
      w_strb_q    <= w_strb;
    end
  end

  // byte merge
  always_comb begin
    old_word.word = mem[aw_idx];
    for (int i = 0; i < 4; i++) begin
      new_word.lanes[i] = w_strb_q[i] ? w_word.lanes[i] : old_word.lanes[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < `RAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (do_write) begin
      mem[aw_idx] <= new_word.word;
    end
  end

  // two-entry read response queue
  assign ar_ready = (rq_count != 2'd2);
  assign ar_fire  = ar_valid && ar_ready;
  assign r_valid  = (rq_count != 2'd0);
  assign r_fire   = r_valid && r_ready;
  assign r_data   = rq_data[rq_rd];
  assign r_resp   = OKAY;

  always_ff @(posedge clk) begin
    if (rstn) begin
      rq_wr    <= 1'b0;
      rq_rd    <= 1'b0;
      rq_count <= 2'd0;
    end else begin
      if (ar_fire) rq_wr <= !rq_wr;
      if (r_fire) rq_rd <= !rq_rd;
      case ({ar_fire, r_fire})
        2'b10:   rq_count <= rq_count + 1'b1;
        2'b01:   rq_count <= rq_count - 1'b1;
        default: rq_count <= rq_count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) rq_data[rq_wr] <= mem[ar_addr[IDX_W+1:2]];
  end

  a_b_needs_slots: assert property (@(posedge clk) disable iff (rstn)
    b_valid |-> aw_full && w_full);

  a_r_stable: assert property (@(posedge clk) disable iff (rstn)
    r_valid && !r_ready |=> r_valid && $stable(r_data));

endmodule

//--- logic/lsu.sv
`include "lsu_cfg.svh"

module lsu (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ld_valid,
  output logic                      ld_ready,
  input  logic [`LSU_ADDR_W-1:0]    ld_addr,
  input  mem_op_pkg::ld_func_e      ld_func,
  output logic                      ld_res_valid,
  input  logic                      ld_res_ready,
  output logic [31:0]               ld_data,
  input  logic                      st_valid,
  output logic                      st_ready,
  input  logic [`LSU_ADDR_W-1:0]    st_addr,
  input  logic [31:0]               st_data,
  input  mem_op_pkg::st_func_e      st_func,
  output logic                      st_done_valid,
  input  logic                      st_done_ready,
  output logic                      ar_valid,
  input  logic                      ar_ready,
  output logic [`LSU_ADDR_W-1:0]    ar_addr,
  input  logic                      r_valid,
  output logic                      r_ready,
  input  logic [31:0]               r_data,
  input  axi_lite_pkg::axi_resp_e   r_resp,
  output logic                      aw_valid,
  input  logic                      aw_ready,
  output logic [`LSU_ADDR_W-1:0]    aw_addr,
  output logic                      w_valid,
  input  logic                      w_ready,
  output logic [31:0]               w_data,
  output logic [3:0]                w_strb,
  input  logic                      b_valid,
  output logic                      b_ready,
  input  axi_lite_pkg::axi_resp_e   b_resp
);
  import mem_op_pkg::*;
  import axi_lite_pkg::*;

  localparam int QD    = `LSU_RD_DEPTH;
  localparam int PTR_W = (QD > 1) ? $clog2(QD) : 1;
  localparam int CNT_W = $clog2(QD + 1);

  ld_func_e               tag_func [QD];
  logic [1:0]             tag_off  [QD];
  logic [PTR_W-1:0]       wr_ptr, rd_ptr;
  logic [CNT_W-1:0]       q_count;
  logic                   q_full, push, pop;
  ld_func_e               head_func;
  logic [1:0]             head_off;
  bus_word_u              rword;
  logic [7:0]             sel_byte;
  logic [15:0]            sel_half;

  logic [1:0]             st_off;
  logic [3:0]             st_mask;
  logic [31:0]            st_wdata;
  logic [3:0]             st_wstrb;
  logic                   st_fire;
  logic                   aw_pend, w_pend;
  logic [`LSU_ADDR_W-1:0] aw_hold;
  logic [31:0]            w_hold_data;
  logic [3:0]             w_hold_strb;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(QD - 1)) return '0;
    return p + 1'b1;
  endfunction

  // load request goes straight to ar, held back when no tag slot is free
  assign q_full   = (q_count == CNT_W'(QD));
  assign ar_valid = ld_valid && !q_full;
  assign ar_addr  = ld_addr;
  assign ld_ready = ar_ready && !q_full;
  assign push     = ar_valid && ar_ready;
  assign pop      = r_valid && r_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      tag_func[wr_ptr] <= ld_func;
      tag_off[wr_ptr]  <= ld_addr[1:0];
    end
  end

  assign head_func    = tag_func[rd_ptr];
  assign head_off     = tag_off[rd_ptr];
  assign ld_res_valid = r_valid;
  assign r_ready      = ld_res_ready;

  // lane select by offset, then extend
  always_comb begin
    rword.word = r_data;
    sel_byte   = rword.lanes[head_off];
    sel_half   = head_off[1] ? {rword.lanes[3], rword.lanes[2]}
                             : {rword.lanes[1], rword.lanes[0]};
    case (head_func)
      LD_BS:   ld_data = {{24{sel_byte[7]}}, sel_byte};
      LD_BU:   ld_data = {24'b0, sel_byte};
      LD_HS:   ld_data = {{16{sel_half[15]}}, sel_half};
      LD_HU:   ld_data = {16'b0, sel_half};
      LD_W:    ld_data = rword.word;
      default: ld_data = rword.word;
    endcase
  end

  // store alignment
  assign st_off = st_addr[1:0];

  always_comb begin
    case (st_func)
      ST_B:    st_mask = 4'b0001;
      ST_H:    st_mask = 4'b0011;
      default: st_mask = 4'b1111;
    endcase
  end

  assign st_wdata = st_data << {st_off, 3'b000};
  assign st_wstrb = st_mask << st_off;
  assign st_fire  = st_valid && st_ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      aw_pend  <= 1'b0;
      w_pend   <= 1'b0;
      st_ready <= 1'b1;
    end else begin
      if (aw_valid && aw_ready) aw_valid <= 1'b0;
      if (w_valid && w_ready) w_valid <= 1'b0;
      if (st_fire) begin
        // busy channel gets staged
        if (aw_valid) aw_pend <= 1'b1;
        else aw_valid <= 1'b1;
        if (w_valid) w_pend <= 1'b1;
        else w_valid <= 1'b1;
        st_ready <= !(aw_valid || w_valid);
      end else begin
        if (aw_pend && !aw_valid) begin
          aw_valid <= 1'b1;
          aw_pend  <= 1'b0;
        end
        if (w_pend && !w_valid) begin
          w_valid <= 1'b1;
          w_pend  <= 1'b0;
        end
        if (!st_ready && (!aw_pend || !aw_valid) && (!w_pend || !w_valid)) begin
          st_ready <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (st_fire) begin
      if (aw_valid) aw_hold <= st_addr;
      else aw_addr <= st_addr;
      if (w_valid) begin
        w_hold_data <= st_wdata;
        w_hold_strb <= st_wstrb;
      end else begin
        w_data <= st_wdata;
        w_strb <= st_wstrb;
      end
    end else begin
      if (aw_pend && !aw_valid) aw_addr <= aw_hold;
      if (w_pend && !w_valid) begin
        w_data <= w_hold_data;
        w_strb <= w_hold_strb;
      end
    end
  end

  // one completion outstanding at a time
  assign b_ready = !st_done_valid;

  always_ff @(posedge clk) begin
    if (rstn) begin
      st_done_valid <= 1'b0;
    end else if (b_valid && b_ready) begin
      st_done_valid <= 1'b1;
    end else if (st_done_ready) begin
      st_done_valid <= 1'b0;
    end
  end

  a_tag_no_overflow: assert property (@(posedge clk) disable iff (rstn)
    q_count <= CNT_W'(QD));

  a_r_has_tag: assert property (@(posedge clk) disable iff (rstn)
    r_valid |-> (q_count != '0) && (r_resp == OKAY));

  a_b_okay: assert property (@(posedge clk) disable iff (rstn)
    b_valid |-> b_resp == OKAY);

  a_aw_stable: assert property (@(posedge clk) disable iff (rstn)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr));

  a_w_stable: assert property (@(posedge clk) disable iff (rstn)
    w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb));

endmodule

//--- logic/axi_lite_pkg.sv
package axi_lite_pkg;

  // one bus word, whole or by byte lane
  typedef union packed {
    logic [31:0]      word;
    logic [3:0][7:0]  lanes;
  } bus_word_u;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

endpackage

//--- logic/mem_op_pkg.sv
package mem_op_pkg;

  // funct3 encoding of loads
  typedef enum logic [2:0] {
    LD_BS = 3'b000,
    LD_HS = 3'b001,
    LD_W  = 3'b010,
    LD_BU = 3'b100,
    LD_HU = 3'b101
  } ld_func_e;

  // funct3 encoding of stores
  typedef enum logic [2:0] {
    ST_B = 3'b000,
    ST_H = 3'b001,
    ST_W = 3'b010
  } st_func_e;

endpackage

//--- logic/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// byte address width on core and bus
`define LSU_ADDR_W 32

// memory depth in 32-bit words, power of two
`define RAM_WORDS 256

// loads allowed in flight
`define LSU_RD_DEPTH 2

`endif
